// File: common/fetch_pkg.sv
/* Read-only single client fetch; thread and argument ids fixed at zero; rnw set means read */
`default_nettype none

package fetch_pkg;

	/* Widths of the memory side */
	localparam int FETCH_ADDR_W = 37;	/* Word address */
	localparam int FETCH_DATA_W = 64;	/* Command word */

	/* FIFO sizing, also the credit limit */
	localparam int FETCH_DEPTH_POW2 = 4;
	localparam int FETCH_DEPTH = 1 << FETCH_DEPTH_POW2;	/* 16 entries */
	localparam int FETCH_CNT_W = FETCH_DEPTH_POW2 + 1;	/* Counts 0 to DEPTH */

	localparam logic [1:0] FETCH_CLIENT_ID = 2'd1;	/* This unit on the memory bus */
	localparam logic FETCH_RNW_READ = 1'b1;	/* Read encoding of rnw */

	/* Address step per fetched command */
	localparam logic [FETCH_ADDR_W-1:0] CMD_WORDS = FETCH_ADDR_W'(1);

	/* Transaction id as coded on the bus */
	typedef struct packed {
		logic [1:0] client;	/* Requesting client */
		logic [2:0] thread;	/* Always zero here */
		logic arg;		/* Always zero here */
	} txnid_t;

	/* Request word, 44 bits */
	typedef struct packed {
		txnid_t txnid;
		logic rnw;
		logic [FETCH_ADDR_W-1:0] addr;
	} rqa_t;

	/* Response status word, 9 bits */
	typedef struct packed {
		txnid_t txnid;	/* Echoed from the request */
		logic rnw;
		logic [1:0] err;	/* Nonzero on memory error */
	} rss_t;

	/* Entry handed to the command decoder, 102 bits */
	typedef struct packed {
		logic [FETCH_ADDR_W-1:0] addr;
		logic [FETCH_DATA_W-1:0] data;
		logic err;	/* Error code set or foreign response */
	} fetch_ent_t;

	/* Id carried by every read this unit sends */
	function automatic txnid_t fetch_txnid();
		txnid_t id;
		id.client = FETCH_CLIENT_ID;
		id.thread = 3'd0;
		id.arg = 1'b0;
		return id;
	endfunction

	/* True when the status answers one of our reads */
	function automatic logic rsp_is_mine(input rss_t rss);
		logic own;
		logic rd;
		own = (rss.txnid.client == FETCH_CLIENT_ID);
		rd = (rss.rnw == FETCH_RNW_READ);
		return own && rd;
	endfunction

endpackage

`default_nettype wire

// File: fetch/fetch_fifo.sv
/* No full flag and no overflow guard; the writer must never push into a full FIFO */
`default_nettype none

module fetch_fifo #(
	parameter type T_PAYLOAD = logic [7:0],	/* Stored word */
	parameter int DEPTH_POW2 = 4		/* log2 of the entry count */
)
(
	input wire clk,
	input wire nrst,
	input wire i_wr,			/* Push i_data */
	input wire T_PAYLOAD i_data,
	input wire i_rd,			/* Pop head, ignored when empty */
	output T_PAYLOAD o_data,		/* Head word, combinational */
	output logic o_vld,			/* Not empty */
	output logic [DEPTH_POW2:0] o_count	/* Fill level */
);

localparam int DEPTH = 1 << DEPTH_POW2;

T_PAYLOAD mem [DEPTH];		/* Storage */
logic [DEPTH_POW2:0] wp;	/* Write pointer with wrap bit */
logic [DEPTH_POW2:0] rp;	/* Read pointer with wrap bit */
logic pop;

assign o_count = wp - rp;	/* Wrap bit makes the difference exact */
assign o_vld = (wp != rp);
assign pop = i_rd && o_vld;
assign o_data = mem[rp[DEPTH_POW2-1:0]];

/* Pointers */
always_ff @(posedge clk or negedge nrst)
begin
	if(!nrst)
	begin
		wp <= '0;
		rp <= '0;
	end
	else
	begin
		if(i_wr)
			wp <= wp + 1'b1;
		if(pop)
			rp <= rp + 1'b1;
	end
end

/* Storage write */
always_ff @(posedge clk)
begin
	if(i_wr)
		mem[wp[DEPTH_POW2-1:0]] <= i_data;
end

endmodule

`default_nettype wire

// File: fetch/fetch_addr_counter.sv
/* Outstanding count wraps silently; the request FSM keeps it at or below the FIFO depth */
`default_nettype none

module fetch_addr_counter (
	input wire clk,
	input wire nrst,
	input wire i_load,				/* Take start address */
	input wire [fetch_pkg::FETCH_ADDR_W-1:0] i_load_addr,
	input wire i_issue,				/* Request accepted by memory */
	input wire i_retire,				/* Response accepted */
	output logic [fetch_pkg::FETCH_ADDR_W-1:0] o_addr,	/* Next address to fetch */
	output logic [fetch_pkg::FETCH_CNT_W-1:0] o_outstanding
);

/* Fetch address */
always_ff @(posedge clk or negedge nrst)
begin
	if(!nrst)
		o_addr <= '0;
	else if(i_load)
		o_addr <= i_load_addr;
	else if(i_issue)
		o_addr <= o_addr + fetch_pkg::CMD_WORDS;	/* Step one command */
end

/* Requests sent but not yet answered */
always_ff @(posedge clk or negedge nrst)
begin
	if(!nrst)
	begin
		o_outstanding <= '0;
	end
	else
	begin
		case({i_issue, i_retire})
		2'b10:
			o_outstanding <= o_outstanding + 1'b1;
		2'b01:
			o_outstanding <= o_outstanding - 1'b1;
		default:
			o_outstanding <= o_outstanding;	/* Both or none */
		endcase
	end
end

endmodule

`default_nettype wire

// File: fetch/fetch_req_fsm.sv
/* Start is ignored while draining; a held request always transfers before drain begins */
`default_nettype none

module fetch_req_fsm (
	input wire clk,
	input wire nrst,
	input wire i_start,			/* One-cycle start pulse */
	input wire [fetch_pkg::FETCH_ADDR_W-1:0] i_addr,	/* Counter address */
	input wire i_stop_drain,		/* One-cycle stop pulse */
	input wire i_rqa_rdy,
	input wire [fetch_pkg::FETCH_CNT_W-1:0] i_outstanding,
	input wire [fetch_pkg::FETCH_CNT_W-1:0] i_ent_count,
	input wire i_addr_fifo_vld,
	input wire i_ent_fifo_vld,
	output fetch_pkg::rqa_t o_rqa,
	output logic o_rqa_wr,
	output logic o_load,		/* Load counter with start address */
	output logic o_issue,		/* Request transfer */
	output logic o_drain,		/* Discard fetched entries */
	output logic o_busy
);

typedef enum logic [1:0] {
	S_IDLE,		/* Waiting for start */
	S_SEND,		/* Request on the bus */
	S_HOLD,		/* Out of credit */
	S_DRAIN		/* Collect and drop leftovers */
} state_t;

state_t state;
logic stop_pend;	/* Stop seen while a request is held */
logic xfer;
logic [fetch_pkg::FETCH_CNT_W:0] credit_use;
logic credit_ok;
logic drain_done;

assign o_rqa_wr = (state == S_SEND);
assign xfer = o_rqa_wr && i_rqa_rdy;
assign o_issue = xfer;
assign o_load = (state == S_IDLE) && i_start && !i_stop_drain;

/* Address follows the counter so it is stable while held */
assign o_rqa = '{txnid: fetch_pkg::fetch_txnid(), rnw: fetch_pkg::FETCH_RNW_READ, addr: i_addr};

/* Slots in use after this edge plus the one to present
 * One more is kept for an entry sitting in the collector register */
assign credit_use = {1'b0, i_outstanding} + {1'b0, i_ent_count} +
	{{fetch_pkg::FETCH_CNT_W{1'b0}}, xfer} + (fetch_pkg::FETCH_CNT_W+1)'(1);
assign credit_ok = credit_use < (fetch_pkg::FETCH_CNT_W+1)'(fetch_pkg::FETCH_DEPTH);

/* Nothing in flight and nothing stored */
assign drain_done = (i_outstanding == '0) && !i_addr_fifo_vld && !i_ent_fifo_vld;

assign o_drain = (state == S_DRAIN) || stop_pend;	/* Output blanked from the stop edge */
assign o_busy = (state != S_IDLE) || i_start || i_stop_drain;

always_ff @(posedge clk or negedge nrst)
begin
	if(!nrst)
	begin
		state <= S_IDLE;
		stop_pend <= 1'b0;
	end
	else
	begin
		case(state)
		S_IDLE:
		begin
			if(i_stop_drain)
				state <= S_DRAIN;	/* Nothing to collect, leaves at once */
			else if(i_start)
				state <= S_SEND;
		end
		S_SEND:
		begin
			if(xfer)
			begin
				stop_pend <= 1'b0;
				if(i_stop_drain || stop_pend)
					state <= S_DRAIN;
				else if(!credit_ok)
					state <= S_HOLD;
			end
			else if(i_stop_drain)
			begin
				stop_pend <= 1'b1;	/* Wait for the held request */
			end
		end
		S_HOLD:
		begin
			if(i_stop_drain)
				state <= S_DRAIN;
			else if(credit_ok)
				state <= S_SEND;
		end
		default:	/* S_DRAIN */
		begin
			if(drain_done)
				state <= S_IDLE;
		end
		endcase
	end
end

endmodule

`default_nettype wire

// File: fetch/fetch_rsp_collect.sv
/* Responses must arrive in request order; status and data are taken on the same edge */
`default_nettype none

module fetch_rsp_collect (
	input wire clk,
	input wire nrst,
	input wire i_rss_vld,				/* Status valid */
	input wire fetch_pkg::rss_t i_rss,
	input wire i_rsd_vld,				/* Data valid */
	input wire [fetch_pkg::FETCH_DATA_W-1:0] i_rsd,
	input wire i_outstanding_nz,			/* Some request unanswered */
	input wire [fetch_pkg::FETCH_ADDR_W-1:0] i_head_addr,	/* Oldest issued address */
	output logic o_rss_rd,
	output logic o_rsd_rd,
	output logic o_retire,				/* Response taken */
	output logic o_ent_wr,				/* Push entry, pops address */
	output fetch_pkg::fetch_ent_t o_ent
);

fetch_pkg::rss_t rss_q;				/* Captured status */
logic [fetch_pkg::FETCH_DATA_W-1:0] rsd_q;	/* Captured command word */
logic xfer;
logic ent_err;

/* Credit guarantees room, so reading only depends on pending requests */
assign o_rss_rd = i_outstanding_nz;
assign o_rsd_rd = i_outstanding_nz;	/* Same level on both channels */

assign xfer = i_rss_vld && i_rsd_vld && o_rss_rd;
assign o_retire = xfer;

/* Entry write one cycle after the transfer */
always_ff @(posedge clk or negedge nrst)
begin
	if(!nrst)
		o_ent_wr <= 1'b0;
	else
		o_ent_wr <= xfer;
end

/* Response payload */
always_ff @(posedge clk)
begin
	if(xfer)
	begin
		rss_q <= i_rss;
		rsd_q <= i_rsd;
	end
end

/* Memory error or a response that is not our read */
assign ent_err = (rss_q.err != 2'b00) || !fetch_pkg::rsp_is_mine(rss_q);

/* Head address matches since answers come in order */
assign o_ent = '{addr: i_head_addr, data: rsd_q, err: ent_err};

endmodule

`default_nettype wire

// File: fetch/fetch_unit.sv
/* Reads only, in-order memory assumed; entries are dropped, not delivered, during drain */
`default_nettype none

module fetch_unit (
	input wire clk,
	input wire nrst,
	/* Memory request channel */
	input wire i_rqa_rdy,
	output fetch_pkg::rqa_t o_rqa,
	output logic o_rqa_wr,
	/* Memory response channels */
	input wire i_rss_vld,
	input wire fetch_pkg::rss_t i_rss,
	output logic o_rss_rd,
	input wire i_rsd_vld,
	input wire [fetch_pkg::FETCH_DATA_W-1:0] i_rsd,
	output logic o_rsd_rd,
	/* Control */
	input wire i_start,
	input wire [fetch_pkg::FETCH_ADDR_W-1:0] i_start_addr,
	input wire i_stop_drain,
	output logic o_busy,
	/* Decoder side */
	output fetch_pkg::fetch_ent_t o_fetch,
	output logic o_fetch_vld,
	input wire i_fetch_rd
);

logic load;
logic issue;
logic retire;
logic drain;
logic [fetch_pkg::FETCH_ADDR_W-1:0] addr;	/* Counter address */
logic [fetch_pkg::FETCH_CNT_W-1:0] outstanding;
logic [fetch_pkg::FETCH_ADDR_W-1:0] head_addr;	/* Address FIFO head */
logic addr_vld;
logic ent_wr;
fetch_pkg::fetch_ent_t ent_in;
logic [fetch_pkg::FETCH_CNT_W-1:0] ent_count;
logic ent_vld;
logic ent_rd;

assign o_fetch_vld = ent_vld && !drain;	/* Hidden while draining */
assign ent_rd = ent_vld && (i_fetch_rd || drain);	/* Drain discards the head */

fetch_req_fsm req_fsm (
	.clk(clk),
	.nrst(nrst),
	.i_start(i_start),
	.i_addr(addr),
	.i_stop_drain(i_stop_drain),
	.i_rqa_rdy(i_rqa_rdy),
	.i_outstanding(outstanding),
	.i_ent_count(ent_count),
	.i_addr_fifo_vld(addr_vld),
	.i_ent_fifo_vld(ent_vld),
	.o_rqa(o_rqa),
	.o_rqa_wr(o_rqa_wr),
	.o_load(load),
	.o_issue(issue),
	.o_drain(drain),
	.o_busy(o_busy)
);

fetch_addr_counter addr_counter (
	.clk(clk),
	.nrst(nrst),
	.i_load(load),
	.i_load_addr(i_start_addr),
	.i_issue(issue),
	.i_retire(retire),
	.o_addr(addr),
	.o_outstanding(outstanding)
);

fetch_rsp_collect rsp_collect (
	.clk(clk),
	.nrst(nrst),
	.i_rss_vld(i_rss_vld),
	.i_rss(i_rss),
	.i_rsd_vld(i_rsd_vld),
	.i_rsd(i_rsd),
	.i_outstanding_nz(|outstanding),
	.i_head_addr(head_addr),
	.o_rss_rd(o_rss_rd),
	.o_rsd_rd(o_rsd_rd),
	.o_retire(retire),
	.o_ent_wr(ent_wr),
	.o_ent(ent_in)
);

/* Addresses of issued reads, popped as their entry is written */
fetch_fifo #(
	.T_PAYLOAD(logic [fetch_pkg::FETCH_ADDR_W-1:0]),
	.DEPTH_POW2(fetch_pkg::FETCH_DEPTH_POW2)
) addr_fifo (
	.clk(clk),
	.nrst(nrst),
	.i_wr(issue),
	.i_data(addr),
	.i_rd(ent_wr),
	.o_data(head_addr),
	.o_vld(addr_vld),
	.o_count()
);

/* Complete entries waiting for the decoder */
fetch_fifo #(
	.T_PAYLOAD(fetch_pkg::fetch_ent_t),
	.DEPTH_POW2(fetch_pkg::FETCH_DEPTH_POW2)
) ent_fifo (
	.clk(clk),
	.nrst(nrst),
	.i_wr(ent_wr),
	.i_data(ent_in),
	.i_rd(ent_rd),
	.o_data(o_fetch),
	.o_vld(ent_vld),
	.o_count(ent_count)
);

endmodule

`default_nettype wire

// File: test/tb_mem_model.sv
/* In-order read responder for simulation only; every request is answered with data, rnw is echoed */
`default_nettype none

module tb_mem_model (
	input wire clk,
	input wire nrst,
	input wire fetch_pkg::rqa_t i_rqa,
	input wire i_rqa_wr,
	output logic o_rqa_rdy,
	output logic o_rss_vld,
	output fetch_pkg::rss_t o_rss,
	output logic o_rsd_vld,
	output logic [fetch_pkg::FETCH_DATA_W-1:0] o_rsd,
	input wire i_rss_rd,
	input wire i_rsd_rd,
	input wire i_err_mode,	/* Error code where address bit 5 is set */
	input wire i_wrong_id,	/* Corrupt the echoed client id */
	input wire i_stall	/* Random request back-pressure */
);

fetch_pkg::rqa_t req_q [$];	/* Accepted requests, oldest first */
int unsigned due_q [$];		/* Cycle from which each answer may show */
int unsigned cycle;
logic req_xfer;
logic rsp_xfer;
logic err_s;
logic wrong_s;
logic stall_s;
fetch_pkg::rqa_t req_word;

initial
begin
	cycle = 0;
	o_rqa_rdy = 1'b0;
	o_rss_vld = 1'b0;
	o_rsd_vld = 1'b0;
	o_rss = '0;
	o_rsd = '0;
	forever
	begin
		@(negedge clk);	/* Handshakes are settled for the coming edge */
		req_xfer = i_rqa_wr && o_rqa_rdy;
		rsp_xfer = o_rss_vld && o_rsd_vld && i_rss_rd && i_rsd_rd;
		req_word = i_rqa;
		@(posedge clk);
		#10;
		err_s = i_err_mode;	/* Test modes, set by the testbench at the falling edge */
		wrong_s = i_wrong_id;
		stall_s = i_stall;
		cycle = cycle + 1;
		if(!nrst)
		begin
			req_q.delete();
			due_q.delete();
		end
		else
		begin
			if(rsp_xfer)
			begin
				void'(req_q.pop_front());	/* Head answered */
				void'(due_q.pop_front());
			end
			if(req_xfer)
			begin
				req_q.push_back(req_word);
				due_q.push_back(cycle + 1 + $urandom_range(5));	/* 1 to 6 cycles */
			end
		end
		/* Oldest request only, so answers stay in order */
		if((req_q.size() != 0) && (due_q[0] <= cycle))
		begin
			o_rss_vld = 1'b1;
			o_rsd_vld = 1'b1;	/* Status and data always together */
			o_rss.txnid = req_q[0].txnid;
			if(wrong_s)
				o_rss.txnid.client = ~req_q[0].txnid.client;
			o_rss.rnw = req_q[0].rnw;
			o_rss.err = (err_s && req_q[0].addr[5]) ? 2'b01 : 2'b00;
			o_rsd = {27'd0, req_q[0].addr} ^ 64'h5a5a_0000_c3c3_0000;
		end
		else
		begin
			o_rss_vld = 1'b0;
			o_rsd_vld = 1'b0;
		end
		o_rqa_rdy = nrst && (!stall_s || ($urandom_range(3) != 0));	/* About one stall in four */
	end
end

endmodule

`default_nettype wire

// File: test/tb_fetch_unit.sv
/* Directed tests against an in-order memory model; the run stops at the first mismatch */
`default_nettype none

module tb_fetch_unit;

localparam int CLK_PERIOD = 100;
localparam int NUM_TESTS = 5;
localparam int WATCHDOG_CYCLES = 4000 * NUM_TESTS;	/* Budget per test times tests */
localparam int IDLE_WAIT = 2000;	/* Cycles allowed for a drain */
localparam int CREDIT_LIMIT = 16;	/* Requests allowed ahead of the decoder */
localparam logic [63:0] DATA_MASK = 64'h5a5a_0000_c3c3_0000;	/* Memory data pattern */

logic clk;
logic nrst;
logic rqa_rdy;
fetch_pkg::rqa_t rqa;
logic rqa_wr;
logic rss_vld;
fetch_pkg::rss_t rss;
logic rss_rd;
logic rsd_vld;
logic [fetch_pkg::FETCH_DATA_W-1:0] rsd;
logic rsd_rd;
logic start;
logic [fetch_pkg::FETCH_ADDR_W-1:0] start_addr;
logic stop_drain;
logic busy;
fetch_pkg::fetch_ent_t fetch_ent;
logic fetch_vld;
logic fetch_rd;
logic err_mode;		/* Memory model modes */
logic wrong_id;
logic stall;
int req_total = 0;	/* Request transfers seen on the bus */
int req_base;		/* req_total when the current fetch started */
int consumed;		/* Entries taken by the decoder since then */
logic [fetch_pkg::FETCH_ADDR_W-1:0] exp_addr;	/* Next address the decoder should see */

fetch_unit fetch_unit_inst (
	.clk(clk),
	.nrst(nrst),
	.i_rqa_rdy(rqa_rdy),
	.o_rqa(rqa),
	.o_rqa_wr(rqa_wr),
	.i_rss_vld(rss_vld),
	.i_rss(rss),
	.o_rss_rd(rss_rd),
	.i_rsd_vld(rsd_vld),
	.i_rsd(rsd),
	.o_rsd_rd(rsd_rd),
	.i_start(start),
	.i_start_addr(start_addr),
	.i_stop_drain(stop_drain),
	.o_busy(busy),
	.o_fetch(fetch_ent),
	.o_fetch_vld(fetch_vld),
	.i_fetch_rd(fetch_rd)
);

tb_mem_model mem (
	.clk(clk),
	.nrst(nrst),
	.i_rqa(rqa),
	.i_rqa_wr(rqa_wr),
	.o_rqa_rdy(rqa_rdy),
	.o_rss_vld(rss_vld),
	.o_rss(rss),
	.o_rsd_vld(rsd_vld),
	.o_rsd(rsd),
	.i_rss_rd(rss_rd),
	.i_rsd_rd(rsd_rd),
	.i_err_mode(err_mode),
	.i_wrong_id(wrong_id),
	.i_stall(stall)
);

initial
begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

/* Hang guard */
initial
begin
	#(CLK_PERIOD * WATCHDOG_CYCLES);
	$display("Timeout, the tests were still running after %0d cycles", WATCHDOG_CYCLES);
	$display("sim failed");
	$fatal(1, "watchdog expired");
end

/* Count request transfers; read only after the following rising edge */
always @(negedge clk)
begin
	if(nrst && rqa_wr && rqa_rdy)
		req_total = req_total + 1;
end

task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("sim failed");
	$fatal(1, "run stopped");
endtask

task automatic check_equal(input string name, input logic [127:0] exp, input logic [127:0] act);
	if(exp !== act)
	begin
		$display("ERR %s expected %0h actual %0h", name, exp, act);
		$display("sim failed");
		$fatal(1, "run stopped");
	end
endtask

/* Entry the decoder should get for address a under the current memory modes */
function automatic fetch_pkg::fetch_ent_t expected_entry(input logic [36:0] a);
	fetch_pkg::fetch_ent_t e;
	e.addr = a;
	e.data = {27'd0, a} ^ DATA_MASK;
	e.err = wrong_id || (err_mode && a[5]);	/* Foreign id flags all */
	return e;
endfunction

/* Start pulse, then the first request one cycle later */
task automatic start_fetch(input string name, input logic [36:0] addr);
	@(posedge clk);
	#10;
	start = 1'b1;
	start_addr = addr;
	exp_addr = addr;
	req_base = req_total;	/* Unit is idle here */
	consumed = 0;
	@(negedge clk);
	check_equal(name, 128'(1'b1), 128'(busy));
	check_equal(name, 128'(1'b0), 128'(rqa_wr));
	@(posedge clk);
	#10;
	start = 1'b0;
	@(negedge clk);
	check_equal(name, 128'(1'b1), 128'(rqa_wr));
	check_equal(name, 128'({6'b01_000_0, 1'b1, addr}), 128'(rqa));	/* Client 1, read */
endtask

/* Take n entries in address order, optionally with random decoder stalls */
task automatic consume_entries(input string name, input int n, input logic rand_rd);
	int got;
	got = 0;
	while(got < n)
	begin
		@(posedge clk);
		#10;
		if(req_total - req_base - consumed > CREDIT_LIMIT)
			fail_run("More than 16 requests were accepted ahead of the decoder");
		fetch_rd = rand_rd ? ($urandom_range(1) == 1) : 1'b1;
		@(negedge clk);
		if(fetch_vld && fetch_rd)
		begin
			check_equal(name, 128'(expected_entry(exp_addr)), 128'(fetch_ent));
			exp_addr = exp_addr + 37'd1;
			got++;
			consumed++;
		end
	end
	@(posedge clk);
	#10;
	fetch_rd = 1'b0;
endtask

/* Stop pulse, then wait for idle with the output blanked */
task automatic stop_and_wait_idle(input string name);
	int extra;
	int n;
	extra = 0;
	n = 0;
	@(posedge clk);
	#10;
	stop_drain = 1'b1;
	fetch_rd = 1'b0;
	@(negedge clk);
	check_equal(name, 128'(1'b1), 128'(busy));
	if(rqa_wr && rqa_rdy)
		extra++;
	@(posedge clk);
	#10;
	stop_drain = 1'b0;
	@(negedge clk);
	while(busy)
	begin
		check_equal(name, 128'(1'b0), 128'(fetch_vld));	/* Blanked from the edge after stop */
		if(rqa_wr && rqa_rdy)
			extra++;
		n++;
		if(n > IDLE_WAIT)
			fail_run("Busy did not fall after the stop pulse");
		@(negedge clk);
	end
	if(extra > 1)
		fail_run("More than one request transferred after the stop pulse");
	check_equal(name, 128'(1'b0), 128'(rqa_wr));
	check_equal(name, 128'(1'b0), 128'(rss_rd));	/* Nothing outstanding */
	check_equal(name, 128'(1'b0), 128'(rsd_rd));
endtask

task automatic test_reset_start();
	@(negedge clk);
	check_equal("reset", 128'(1'b0), 128'(rqa_wr));
	check_equal("reset", 128'(1'b0), 128'(rss_rd));
	check_equal("reset", 128'(1'b0), 128'(rsd_rd));
	check_equal("reset", 128'(1'b0), 128'(fetch_vld));
	check_equal("reset", 128'(1'b0), 128'(busy));
	start_fetch("reset", 37'h0_0000_0100);
	consume_entries("reset", 4, 1'b0);
	stop_and_wait_idle("reset");
endtask

task automatic test_sequential();
	start_fetch("sequential", 37'h0_0000_1000);
	consume_entries("sequential", 40, 1'b0);
	stop_and_wait_idle("sequential");
endtask

task automatic test_backpressure();
	stall = 1'b1;
	start_fetch("backpressure", 37'h1f_ffff_fff0);	/* Crosses the address wrap */
	consume_entries("backpressure", 60, 1'b1);
	stop_and_wait_idle("backpressure");
endtask

task automatic test_errors();
	err_mode = 1'b1;
	start_fetch("errors", 37'h0_0000_0030);	/* Bit 5 toggles every 32 words */
	consume_entries("errors", 40, 1'b0);
	stop_and_wait_idle("errors");
	err_mode = 1'b0;
	wrong_id = 1'b1;
	start_fetch("wrong_id", 37'h0_0000_0200);
	consume_entries("wrong_id", 16, 1'b1);
	stop_and_wait_idle("wrong_id");
	wrong_id = 1'b0;
endtask

task automatic test_drain_restart();
	stall = 1'b1;
	start_fetch("drain", 37'h0_dead_0000);
	consume_entries("drain", 10, 1'b1);
	stop_and_wait_idle("drain");
	start_fetch("drain", 37'h1_0000_0100);	/* New address, no leftovers expected */
	consume_entries("drain", 12, 1'b1);
	stop_and_wait_idle("drain");
	stall = 1'b0;
endtask

initial
begin
	void'($urandom(32'hfd9a));
	nrst = 1'b0;
	start = 1'b0;
	start_addr = '0;
	stop_drain = 1'b0;
	fetch_rd = 1'b0;
	err_mode = 1'b0;
	wrong_id = 1'b0;
	stall = 1'b0;
	exp_addr = '0;
	req_base = 0;
	consumed = 0;
	repeat(16) @(posedge clk);
	#10;
	nrst = 1'b1;
	test_reset_start();
	test_sequential();
	test_backpressure();
	test_errors();
	test_drain_restart();
	$display("sim passed");
	$finish;
end

endmodule

`default_nettype wire

// File: build.f
common/fetch_pkg.sv
fetch/fetch_fifo.sv
fetch/fetch_addr_counter.sv
fetch/fetch_req_fsm.sv
fetch/fetch_rsp_collect.sv
fetch/fetch_unit.sv
test/tb_mem_model.sv
test/tb_fetch_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module tb_fetch_unit -f build.f -o tb_fetch_unit
./obj_dir/tb_fetch_unit | tee sim.log

if grep -qx "sim passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
